// ==== build.f ====
verilog/stream_pkg.sv
verilog/mem_pkg.sv
verilog/lane_rd_if.sv
verilog/read_arbiter.sv
verilog/fetch_data.sv
verilog/lane_gather.sv
verilog/fetch_top.sv
dv/tb_mem_responder.sv
dv/fetch_tb.sv

// ==== dv/fetch_tb.sv ====
`default_nettype none

module fetch_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic clk, rst, en, start, pop;
  mem_pkg::addr_t    base_addr, mem_addr;
  mem_pkg::count_t   words_per_lane;
  logic              mem_rd, mem_valid, beat_valid, done;
  stream_pkg::word_t mem_data;
  stream_pkg::beat_t beat_data;

  int seed = 32'h3bfd_ea94;
  int errors = 0;
  int rd_total = 0;
  int rd_hits [int];  // reads seen per word address.

  // runs: plain, wrapping with en toggled, long back-pressure stretch.
  mem_pkg::addr_t  run_base  [3] = '{12'h100, 12'hffa, 12'h240};
  mem_pkg::count_t run_words [3] = '{8'd5, 8'd9, 8'd6};
  int              run_hold  [3] = '{0, 0, 160};
  bit              run_en_rand [3] = '{1'b0, 1'b1, 1'b1};

  fetch_top dut (.*);

  tb_mem_responder u_mem (
    .clk       (clk),
    .mem_rd    (mem_rd),
    .mem_addr  (mem_addr),
    .mem_valid (mem_valid),
    .mem_data  (mem_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(negedge clk) begin
    if (mem_rd) begin
      rd_total++;
      if (rd_hits.exists(int'(mem_addr))) rd_hits[int'(mem_addr)]++;
      else rd_hits[int'(mem_addr)] = 1;
    end
  end

  task automatic compare(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", what, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // beat j is chunk j%CHUNKS of word group j/CHUNKS, lane 0 in the low bits.
  function automatic stream_pkg::beat_t expected_beat(input mem_pkg::addr_t base, input int j);
    stream_pkg::beat_t b;
    stream_pkg::word_t w;
    int g;
    int k;
    g = j / stream_pkg::CHUNKS;
    k = j % stream_pkg::CHUNKS;
    for (int i = 0; i < stream_pkg::NUM_LANES; i++) begin
      w = u_mem.mem[mem_pkg::addr_t'(base + g * stream_pkg::NUM_LANES + i)];
      b[i*stream_pkg::CHUNK_W +: stream_pkg::CHUNK_W] =
          w[k*stream_pkg::CHUNK_W +: stream_pkg::CHUNK_W];
    end
    return b;
  endfunction

  task automatic run_test(input string name, input mem_pkg::addr_t base,
                          input mem_pkg::count_t wpl, input int hold, input bit en_rand);
    int total;
    int seen;
    int rd_start;
    int mid;
    int a;
    bit took;
    total    = wpl * stream_pkg::CHUNKS;
    seen     = 0;
    took     = 1'b0;
    rd_start = rd_total;
    rd_hits.delete();
    @(negedge clk);
    base_addr      = base;
    words_per_lane = wpl;
    start          = 1'b1;
    en             = 1'b1;
    pop            = 1'b0;
    @(negedge clk);
    start = 1'b0;
    if (hold > 0) begin
      repeat (hold / 2) @(negedge clk);
      #2;
      mid = rd_total;
      compare({name, " reads while held"}, 1,
              (mid - rd_start) <= 2 * stream_pkg::NUM_LANES + mem_pkg::TAG_DEPTH);
      repeat (hold - hold / 2) @(negedge clk);
      #2;
      compare({name, " reads after stall"}, mid, rd_total);  // reads must have stopped.
    end
    while (seen < total) begin
      @(negedge clk);
      if (took) begin
        compare($sformatf("%s beat %0d", name, seen), expected_beat(base, seen), beat_data);
        seen++;
      end
      compare({name, " done"}, seen == total, done);
      en  = en_rand ? ($random(seed) % 4 != 0) : 1'b1;
      pop = ($random(seed) % 2 != 0);
      #1;
      took = beat_valid && pop;
    end
    en  = 1'b1;
    pop = 1'b0;
    compare({name, " read count"}, wpl * stream_pkg::NUM_LANES, rd_total - rd_start);
    for (int g = 0; g < wpl; g++) begin
      for (int i = 0; i < stream_pkg::NUM_LANES; i++) begin
        a = int'(mem_pkg::addr_t'(base + g * stream_pkg::NUM_LANES + i));
        compare($sformatf("%s reads of %h", name, a), 1, rd_hits.exists(a) ? rd_hits[a] : 0);
      end
    end
  endtask

  initial begin
    int limit;
    limit = 40;
    for (int r = 0; r < 3; r++) begin
      limit += 40 * run_words[r] * stream_pkg::CHUNKS + run_hold[r] + 10;
    end
    repeat (limit) @(posedge clk);
    $display("timeout: no end of test after %0d cycles", limit);
    $display("FAIL: see errors above");
    $fatal(1);
  end

  initial begin
    rst            = 1'b1;
    en             = 1'b1;
    start          = 1'b0;
    pop            = 1'b0;
    base_addr      = '0;
    words_per_lane = '0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    compare("reset mem_rd", 0, mem_rd);
    compare("reset beat_valid", 0, beat_valid);
    compare("reset done", 0, done);
    for (int r = 0; r < 3; r++) begin
      run_test($sformatf("run%0d", r), run_base[r], run_words[r], run_hold[r], run_en_rand[r]);
    end
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tb_mem_responder.sv ====
`default_nettype none

module tb_mem_responder (
  input  wire logic                clk,
  input  wire logic                mem_rd,
  input  wire mem_pkg::addr_t      mem_addr,
  output logic                     mem_valid,
  output stream_pkg::word_t        mem_data
);

  timeunit 1ns;
  timeprecision 100ps;

  stream_pkg::word_t mem [2**mem_pkg::ADDR_W];
  mem_pkg::addr_t    addr_q [$];
  int                delay_q [$];  // cycles left once an entry reaches the head.
  int                seed = 32'h3bfd_ea94;

  initial begin
    mem_valid = 1'b0;
    mem_data  = '0;
    for (int a = 0; a < 2**mem_pkg::ADDR_W; a++) begin
      // the whole address is folded into each word.
      mem[a] = {$random(seed), $random(seed), $random(seed), $random(seed)} ^
               stream_pkg::word_t'(a);
    end
  end

  // answers in issue order, 1 to 6 cycles after each mem_rd.
  always @(negedge clk) begin
    mem_valid <= 1'b0;
    if (mem_rd) begin
      addr_q.push_back(mem_addr);
      delay_q.push_back(int'($unsigned($random(seed)) % 6) + 1);
    end
    if (addr_q.size() != 0) begin
      if (delay_q[0] == 0) begin
        mem_valid <= 1'b1;
        mem_data  <= mem[addr_q.pop_front()];
        void'(delay_q.pop_front());
      end else begin
        delay_q[0] = delay_q[0] - 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fetch_data.sv ====
`default_nettype none

module fetch_data (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          en,
  lane_rd_if.lane            rd,
  input  wire logic          pop_data,
  output logic               available_pop,
  output stream_pkg::chunk_t data_out
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT,
    RD_HOLD
  } rd_state_t;

  typedef enum logic {
    CTL_IDLE,
    CTL_SHIFT
  } ctl_state_t;

  rd_state_t  rd_state;
  ctl_state_t ctl_state;
  stream_pkg::word_t buffer;
  stream_pkg::word_t shift_reg;
  logic [stream_pkg::CHUNKS-1:0] chunk_sel;  // one-hot, msb is the final chunk.
  logic has_buffer;
  logic last_chunk;
  logic pop_en;
  logic buffer_take;

  assign data_out   = shift_reg[stream_pkg::CHUNK_W-1:0];
  assign has_buffer = (rd_state == RD_HOLD);
  assign last_chunk = chunk_sel[stream_pkg::CHUNKS-1];
  assign pop_en     = en && pop_data && (ctl_state == CTL_SHIFT);

  // buffer drains into the shifter when idle, or right as the last chunk leaves.
  assign buffer_take = en && has_buffer &&
                       ((ctl_state == CTL_IDLE) || (pop_en && last_chunk));

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state        <= RD_IDLE;
      rd.request_read <= 1'b0;
    end else begin
      rd.request_read <= 1'b0;
      case (rd_state)
        RD_IDLE: begin
          if (en && rd.available_read) begin
            rd.request_read <= 1'b1;
            rd_state        <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          // the response is a single pulse, so it is taken even with en low.
          if (rd.data_valid) rd_state <= RD_HOLD;
        end
        RD_HOLD: begin
          if (buffer_take) rd_state <= RD_IDLE;
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_state == RD_WAIT && rd.data_valid) buffer <= rd.read_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctl_state     <= CTL_IDLE;
      available_pop <= 1'b0;
      chunk_sel     <= '0;
    end else if (en) begin
      case (ctl_state)
        CTL_IDLE: begin
          if (buffer_take) begin
            chunk_sel     <= stream_pkg::CHUNKS'(1);
            available_pop <= 1'b1;
            ctl_state     <= CTL_SHIFT;
          end
        end
        CTL_SHIFT: begin
          if (pop_en) begin
            if (!last_chunk) begin
              chunk_sel <= chunk_sel << 1;
            end else if (has_buffer) begin
              chunk_sel <= stream_pkg::CHUNKS'(1);  // back to back, no bubble.
            end else begin
              chunk_sel     <= '0;
              available_pop <= 1'b0;
              ctl_state     <= CTL_IDLE;
            end
          end
        end
        default: ctl_state <= CTL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (buffer_take) begin
      shift_reg <= buffer;
    end else if (pop_en) begin
      shift_reg <= shift_reg >> stream_pkg::CHUNK_W;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fetch_top.sv ====
`default_nettype none

module fetch_top (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               en,
  input  wire logic               start,
  input  wire mem_pkg::addr_t     base_addr,
  input  wire mem_pkg::count_t    words_per_lane,
  output logic                    mem_rd,
  output mem_pkg::addr_t          mem_addr,
  input  wire logic               mem_valid,
  input  wire stream_pkg::word_t  mem_data,
  input  wire logic               pop,
  output logic                    beat_valid,
  output stream_pkg::beat_t       beat_data,
  output logic                    done
);

  lane_rd_if lane_rd [stream_pkg::NUM_LANES] ();

  logic               lane_avail [stream_pkg::NUM_LANES];
  logic               lane_pop   [stream_pkg::NUM_LANES];
  stream_pkg::chunk_t lane_chunk [stream_pkg::NUM_LANES];

  read_arbiter u_arbiter (
    .clk            (clk),
    .rst            (rst),
    .en             (en),
    .start          (start),
    .base_addr      (base_addr),
    .words_per_lane (words_per_lane),
    .lanes          (lane_rd),
    .mem_rd         (mem_rd),
    .mem_addr       (mem_addr),
    .mem_valid      (mem_valid),
    .mem_data       (mem_data)
  );

  for (genvar i = 0; i < stream_pkg::NUM_LANES; i++) begin : g_lane
    fetch_data u_lane (
      .clk           (clk),
      .rst           (rst),
      .en            (en),
      .rd            (lane_rd[i]),
      .pop_data      (lane_pop[i]),
      .available_pop (lane_avail[i]),
      .data_out      (lane_chunk[i])
    );
  end

  lane_gather u_gather (
    .clk            (clk),
    .rst            (rst),
    .en             (en),
    .start          (start),
    .words_per_lane (words_per_lane),
    .available_pop  (lane_avail),
    .data_out       (lane_chunk),
    .pop_data       (lane_pop),
    .pop            (pop),
    .beat_valid     (beat_valid),
    .beat_data      (beat_data),
    .done           (done)
  );

endmodule

`default_nettype wire

// ==== verilog/lane_gather.sv ====
`default_nettype none

module lane_gather (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               en,
  input  wire logic               start,
  input  wire mem_pkg::count_t    words_per_lane,
  input  wire logic               available_pop [stream_pkg::NUM_LANES],
  input  wire stream_pkg::chunk_t data_out [stream_pkg::NUM_LANES],
  output logic                    pop_data [stream_pkg::NUM_LANES],
  input  wire logic               pop,
  output logic                    beat_valid,
  output stream_pkg::beat_t       beat_data,
  output logic                    done
);

  logic [$bits(mem_pkg::count_t)+$clog2(stream_pkg::CHUNKS)-1:0] beat_cnt;
  logic [$bits(mem_pkg::count_t)+$clog2(stream_pkg::CHUNKS)-1:0] beat_target;
  stream_pkg::beat_t beat_next;
  logic all_avail;
  logic take;

  always_comb begin
    all_avail = 1'b1;
    for (int i = 0; i < stream_pkg::NUM_LANES; i++) begin
      all_avail = all_avail & available_pop[i];
      beat_next[i*stream_pkg::CHUNK_W +: stream_pkg::CHUNK_W] = data_out[i];  // lane 0 low.
      pop_data[i] = take;
    end
  end

  assign beat_valid = all_avail && en;
  assign take       = beat_valid && pop;

  always_ff @(posedge clk) begin
    if (take) beat_data <= beat_next;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt    <= '0;
      beat_target <= '0;
      done        <= 1'b0;
    end else if (start) begin
      beat_cnt    <= '0;
      beat_target <= $bits(beat_target)'(words_per_lane * stream_pkg::CHUNKS);
      done        <= (words_per_lane == '0);
    end else if (take) begin
      beat_cnt <= beat_cnt + 1'b1;
      if (beat_cnt + 1'b1 == beat_target) done <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lane_rd_if.sv ====
`default_nettype none

interface lane_rd_if;

  logic               available_read;  // lane may ask for its next word.
  logic               request_read;    // one-cycle pulse from the lane.
  logic               data_valid;      // one-cycle pulse with the word.
  stream_pkg::word_t  read_data;

  modport arb (
    output available_read,
    output data_valid,
    output read_data,
    input  request_read
  );

  modport lane (
    input  available_read,
    input  data_valid,
    input  read_data,
    output request_read
  );

endinterface

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  localparam int ADDR_W    = 12;  // word address, not byte.
  localparam int TAG_DEPTH = 4;   // reads allowed in flight.

  typedef logic [ADDR_W-1:0] addr_t;

  // tag fifo entry, names the lane that owns the next response.
  typedef logic [1:0] lane_id_t;

  typedef logic [7:0] count_t;    // words per lane for one run.

endpackage

`default_nettype wire

// ==== verilog/read_arbiter.sv ====
`default_nettype none

module read_arbiter (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                en,
  input  wire logic                start,
  input  wire mem_pkg::addr_t      base_addr,
  input  wire mem_pkg::count_t     words_per_lane,
  lane_rd_if.arb                   lanes [stream_pkg::NUM_LANES],
  output logic                     mem_rd,
  output mem_pkg::addr_t           mem_addr,
  input  wire logic                mem_valid,
  input  wire stream_pkg::word_t   mem_data
);

  mem_pkg::addr_t   next_addr [stream_pkg::NUM_LANES];
  mem_pkg::count_t  remaining [stream_pkg::NUM_LANES];
  mem_pkg::lane_id_t tag_mem [mem_pkg::TAG_DEPTH];
  logic [$clog2(mem_pkg::TAG_DEPTH)-1:0] wr_ptr;
  logic [$clog2(mem_pkg::TAG_DEPTH)-1:0] rd_ptr;
  mem_pkg::lane_id_t tag_head;
  mem_pkg::lane_id_t rr_ptr;
  mem_pkg::lane_id_t grant_id;
  logic grant_vld;
  logic [stream_pkg::NUM_LANES-1:0] grant_mask;
  logic [stream_pkg::NUM_LANES-1:0] req;
  logic [stream_pkg::NUM_LANES-1:0] pend_q;     // asked but not yet issued.
  logic [stream_pkg::NUM_LANES-1:0] want;
  logic [stream_pkg::NUM_LANES-1:0] in_flight;  // asked and not yet answered.
  logic [stream_pkg::NUM_LANES-1:0] resp_hit;
  logic room;

  assign tag_head = tag_mem[rd_ptr];
  assign want     = pend_q | req;
  // every lane in flight holds or will hold one tag.
  assign room     = $countones(in_flight) < mem_pkg::TAG_DEPTH;

  for (genvar i = 0; i < stream_pkg::NUM_LANES; i++) begin : g_lane
    assign req[i]      = lanes[i].request_read;
    assign resp_hit[i] = mem_valid && (tag_head == mem_pkg::lane_id_t'(i));
    assign lanes[i].available_read = (remaining[i] != '0) && !in_flight[i] && room;
    assign lanes[i].data_valid     = resp_hit[i];
    assign lanes[i].read_data      = mem_data;
  end

  // round-robin pick, starting after the last lane served.
  always_comb begin
    mem_pkg::lane_id_t idx;
    grant_vld  = 1'b0;
    grant_id   = rr_ptr;
    grant_mask = '0;
    for (int k = 0; k < stream_pkg::NUM_LANES; k++) begin
      idx = rr_ptr + mem_pkg::lane_id_t'(k);
      if (!grant_vld && want[idx]) begin
        grant_vld        = 1'b1;
        grant_id         = idx;
        grant_mask[idx]  = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_rd    <= 1'b0;
      pend_q    <= '0;
      in_flight <= '0;
      rr_ptr    <= '0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      for (int i = 0; i < stream_pkg::NUM_LANES; i++) begin
        remaining[i] <= '0;
      end
    end else begin
      mem_rd    <= 1'b0;
      pend_q    <= want;
      in_flight <= (in_flight | req) & ~resp_hit;  // responses are never held off.
      if (mem_valid) rd_ptr <= rd_ptr + 1'b1;
      if (en && grant_vld) begin
        mem_rd              <= 1'b1;
        pend_q              <= want & ~grant_mask;
        remaining[grant_id] <= remaining[grant_id] - 1'b1;
        rr_ptr              <= grant_id + 1'b1;
        wr_ptr              <= wr_ptr + 1'b1;
      end
      if (start) begin
        for (int i = 0; i < stream_pkg::NUM_LANES; i++) begin
          remaining[i] <= words_per_lane;
        end
      end
    end
  end

  // lane i walks base+i, base+i+N, base+i+2N ...
  always_ff @(posedge clk) begin
    if (en && grant_vld) begin
      mem_addr            <= next_addr[grant_id];
      tag_mem[wr_ptr]     <= grant_id;
      next_addr[grant_id] <= next_addr[grant_id] +
                             mem_pkg::addr_t'(stream_pkg::NUM_LANES);
    end
    if (start) begin
      for (int i = 0; i < stream_pkg::NUM_LANES; i++) begin
        next_addr[i] <= base_addr + mem_pkg::addr_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/stream_pkg.sv ====
`default_nettype none

package stream_pkg;

  localparam int NUM_LANES = 4;    // fetch lanes drained together.
  localparam int WORD_W    = 128;  // memory word.
  localparam int CHUNK_W   = 16;   // lane output.

  // chunks per word, each lane shifts out this many per fill.
  localparam int CHUNKS = WORD_W / CHUNK_W;

  // one gathered beat holds one chunk from every lane.
  localparam int BEAT_W = NUM_LANES * CHUNK_W;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [CHUNK_W-1:0] chunk_t;
  typedef logic [BEAT_W-1:0]  beat_t;

endpackage

`default_nettype wire
